/* design/uart_pkg.sv */
package uart_pkg;

    localparam int DBIT    = 8;     // Data bits per frame
    localparam int SB_TICK = 16;    // Ticks in one stop bit
    localparam int DVSR    = 163;   // Tick every DVSR+1 clocks
    localparam int DVSR_W  = 8;     // Divisor counter width
    localparam int FIFO_W  = 2;     // FIFO address bits, 4 entries

    typedef logic [DBIT-1:0] uart_byte_t;

    // Head of the receive FIFO as the command sequencer sees it
    typedef struct packed {
        uart_byte_t data;           // Valid while empty is low
        logic       empty;
    } rx_side_t;

endpackage

/* design/calc_pkg.sv */
package calc_pkg;

    localparam uart_pkg::uart_byte_t OP_ADD = 8'h01;   // Wraps modulo 256
    localparam uart_pkg::uart_byte_t OP_SUB = 8'h02;   // Wraps modulo 256
    localparam uart_pkg::uart_byte_t OP_AND = 8'h03;
    localparam uart_pkg::uart_byte_t OP_OR  = 8'h04;

    typedef enum logic [2:0] {
        IDLE,       // Waiting for the opcode byte
        GET_OP1,
        GET_OP2,
        COMPUTE,    // Result register loads here
        SEND        // Held while the TX FIFO is full
    } calc_state_t;

    typedef uart_pkg::uart_byte_t calc_word_t;

endpackage

/* design/baud_gen.sv */
`timescale 1ns/1ps

module baud_gen (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick     // One-cycle pulse, 16 per bit period
);
    import uart_pkg::*;

    logic [DVSR_W-1:0] cnt_reg;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            cnt_reg <= '0;
        else if (cnt_reg == DVSR)
            cnt_reg <= '0;                  // Wrap after DVSR+1 clocks
        else
            cnt_reg <= cnt_reg + 1'b1;
    end

    assign o_tick = (cnt_reg == DVSR);

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rx,          // Serial line, idles high
    input  logic                 i_tick,        // 16x oversampling tick
    output logic                 o_rx_done,     // One-cycle pulse per byte
    output uart_pkg::uart_byte_t o_dout
);
    import uart_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t               state_reg, state_next;
    logic [3:0]              s_reg, s_next;     // Ticks within a bit
    logic [$clog2(DBIT)-1:0] n_reg, n_next;     // Data bits received
    uart_byte_t              b_reg, b_next;     // Shift register, LSB first
    logic [1:0]              rx_sync;           // Two-flop synchronizer
    logic                    rx_bit;

    assign rx_bit = rx_sync[1];
    assign o_dout = b_reg;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            rx_sync   <= 2'b11;                 // Line idle
            state_reg <= RX_IDLE;
            s_reg     <= '0;
            n_reg     <= '0;
        end
        else
        begin
            rx_sync   <= {rx_sync[0], i_rx};
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    always_comb
    begin
        state_next = state_reg;
        s_next     = s_reg;
        n_next     = n_reg;
        b_next     = b_reg;
        o_rx_done  = 1'b0;
        case (state_reg)
            RX_IDLE:
            begin
                if (!rx_bit)
                begin
                    state_next = RX_START;          // Falling start edge
                    s_next     = '0;
                end
            end
            RX_START:
            begin
                if (i_tick)
                begin
                    if (s_reg == 4'd7)
                    begin
                        state_next = RX_DATA;       // Middle of start bit
                        s_next     = '0;
                        n_next     = '0;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            RX_DATA:
            begin
                if (i_tick)
                begin
                    if (s_reg == 4'd15)
                    begin
                        s_next = '0;
                        b_next = {rx_bit, b_reg[DBIT-1:1]};
                        if (n_reg == DBIT - 1)
                            state_next = RX_STOP;
                        else
                            n_next = n_reg + 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            RX_STOP:
            begin
                if (i_tick)
                begin
                    if (s_reg == SB_TICK - 1)
                    begin
                        state_next = RX_IDLE;       // At stop-bit midpoint
                        o_rx_done  = 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            default: state_next = RX_IDLE;
        endcase
    end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_tx_start,    // Level, sampled when idle
    input  logic                 i_tick,
    input  uart_pkg::uart_byte_t i_din,
    output logic                 o_tx_done,     // Pulse at end of stop bit
    output logic                 o_tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t               state_reg, state_next;
    logic [3:0]              s_reg, s_next;
    logic [$clog2(DBIT)-1:0] n_reg, n_next;
    uart_byte_t              b_reg, b_next;     // Bits still to shift out
    logic                    tx_reg, tx_next;

    assign o_tx = tx_reg;                       // Straight from a flop

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= TX_IDLE;
            s_reg     <= '0;
            n_reg     <= '0;
            tx_reg    <= 1'b1;                  // Line idles high
        end
        else
        begin
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
            tx_reg    <= tx_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    always_comb
    begin
        state_next = state_reg;
        s_next     = s_reg;
        n_next     = n_reg;
        b_next     = b_reg;
        tx_next    = 1'b1;
        o_tx_done  = 1'b0;
        case (state_reg)
            TX_IDLE:
            begin
                if (i_tx_start)
                begin
                    state_next = TX_START;
                    s_next     = '0;
                    b_next     = i_din;
                end
            end
            TX_START:
            begin
                tx_next = 1'b0;
                if (i_tick)
                begin
                    if (s_reg == 4'd15)
                    begin
                        state_next = TX_DATA;
                        s_next     = '0;
                        n_next     = '0;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            TX_DATA:
            begin
                tx_next = b_reg[0];                 // LSB first
                if (i_tick)
                begin
                    if (s_reg == 4'd15)
                    begin
                        s_next = '0;
                        b_next = b_reg >> 1;
                        if (n_reg == DBIT - 1)
                            state_next = TX_STOP;
                        else
                            n_next = n_reg + 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            TX_STOP:
            begin
                if (i_tick)
                begin
                    if (s_reg == SB_TICK - 1)
                    begin
                        state_next = TX_IDLE;
                        o_tx_done  = 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            default: state_next = TX_IDLE;
        endcase
    end

endmodule

/* design/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rd,          // Pop, ignored when empty
    input  logic                 i_wr,          // Push, ignored when full
    input  uart_pkg::uart_byte_t i_w_data,
    output uart_pkg::uart_byte_t o_r_data,      // Show-ahead head entry
    output logic                 o_empty,
    output logic                 o_full
);
    import uart_pkg::*;

    uart_byte_t        mem [2**FIFO_W];
    logic [FIFO_W-1:0] w_ptr, r_ptr;
    logic [FIFO_W-1:0] w_ptr_inc, r_ptr_inc;
    logic              wr_en, rd_en;

    assign wr_en     = i_wr & ~o_full;
    assign rd_en     = i_rd & ~o_empty;
    assign w_ptr_inc = w_ptr + 1'b1;
    assign r_ptr_inc = r_ptr + 1'b1;
    assign o_r_data  = mem[r_ptr];

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            mem[w_ptr] <= i_w_data;
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            w_ptr   <= '0;
            r_ptr   <= '0;
            o_empty <= 1'b1;
            o_full  <= 1'b0;
        end
        else
        begin
            case ({wr_en, rd_en})
                2'b01:
                begin
                    r_ptr   <= r_ptr_inc;
                    o_full  <= 1'b0;
                    o_empty <= (r_ptr_inc == w_ptr);    // Last entry popped
                end
                2'b10:
                begin
                    w_ptr   <= w_ptr_inc;
                    o_empty <= 1'b0;
                    o_full  <= (w_ptr_inc == r_ptr);    // Wrapped onto head
                end
                2'b11:
                begin
                    w_ptr <= w_ptr_inc;                 // Occupancy unchanged
                    r_ptr <= r_ptr_inc;
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/uart_top.sv */
`timescale 1ns/1ps

module uart_top (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rd_uart,     // Pop RX FIFO
    input  logic                 i_wr_uart,     // Push TX FIFO
    input  logic                 i_rx,
    input  uart_pkg::uart_byte_t i_w_data,
    output uart_pkg::rx_side_t   o_rx,          // RX FIFO head and empty
    output logic                 o_tx_full,
    output logic                 o_tx
);
    import uart_pkg::*;

    logic       tick;
    logic       rx_done, tx_done;
    logic       rx_empty, tx_empty;
    uart_byte_t rx_dout, rx_head, tx_head;

    assign o_rx = '{data: rx_head, empty: rx_empty};

    baud_gen u_baud (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_rx (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rx      (i_rx),
        .i_tick    (tick),
        .o_rx_done (rx_done),
        .o_dout    (rx_dout)
    );

    byte_fifo u_rx_fifo (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rd     (i_rd_uart),
        .i_wr     (rx_done),        // Byte dropped when full
        .i_w_data (rx_dout),
        .o_r_data (rx_head),
        .o_empty  (rx_empty),
        .o_full   ()
    );

    byte_fifo u_tx_fifo (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rd     (tx_done),        // Pop once the frame is out
        .i_wr     (i_wr_uart),
        .i_w_data (i_w_data),
        .o_r_data (tx_head),
        .o_empty  (tx_empty),
        .o_full   (o_tx_full)
    );

    uart_tx u_tx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tx_start (~tx_empty),
        .i_tick     (tick),
        .i_din      (tx_head),
        .o_tx_done  (tx_done),
        .o_tx       (o_tx)
    );

endmodule

/* design/uart_calc.sv */
`timescale 1ns/1ps

module uart_calc (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_rx,          // Opcode, operand one, operand two
    output logic o_tx           // One result byte per command
);
    import uart_pkg::*;
    import calc_pkg::*;

    calc_state_t state_reg, state_next;
    calc_word_t  opcode_reg, op1_reg, op2_reg;
    calc_word_t  result_reg, result_next;
    calc_word_t  alu_out;
    rx_side_t    rx_head;
    logic        tx_full;
    logic        rd_uart, wr_uart;

    uart_top u_uart (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rd_uart (rd_uart),
        .i_wr_uart (wr_uart),
        .i_rx      (i_rx),
        .i_w_data  (result_reg),    // Registered result
        .o_rx      (rx_head),
        .o_tx_full (tx_full),
        .o_tx      (o_tx)
    );

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg  <= IDLE;
            result_reg <= '0;
        end
        else
        begin
            state_reg  <= state_next;
            result_reg <= result_next;
        end
    end

    // Capture each byte on its pop
    always_ff @(posedge i_clk)
    begin
        if (rd_uart)
        begin
            case (state_reg)
                IDLE:    opcode_reg <= rx_head.data;
                GET_OP1: op1_reg    <= rx_head.data;
                GET_OP2: op2_reg    <= rx_head.data;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        case (opcode_reg)
            OP_ADD:  alu_out = op1_reg + op2_reg;   // Wraps
            OP_SUB:  alu_out = op1_reg - op2_reg;
            OP_AND:  alu_out = op1_reg & op2_reg;
            OP_OR:   alu_out = op1_reg | op2_reg;
            default: alu_out = '0;                  // Unknown opcode
        endcase
    end

    always_comb
    begin
        state_next  = state_reg;
        result_next = result_reg;
        rd_uart     = 1'b0;
        wr_uart     = 1'b0;
        case (state_reg)
            IDLE:
            begin
                if (!rx_head.empty)
                begin
                    rd_uart    = 1'b1;
                    state_next = GET_OP1;
                end
            end
            GET_OP1:
            begin
                if (!rx_head.empty)
                begin
                    rd_uart    = 1'b1;
                    state_next = GET_OP2;
                end
            end
            GET_OP2:
            begin
                if (!rx_head.empty)
                begin
                    rd_uart    = 1'b1;
                    state_next = COMPUTE;
                end
            end
            COMPUTE:
            begin
                result_next = alu_out;
                state_next  = SEND;
            end
            SEND:
            begin
                if (!tx_full)
                begin
                    wr_uart    = 1'b1;          // Hold here under back-pressure
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

endmodule

/* verification/tb_uart_calc.sv */
`timescale 1ns/1ps

module tb_uart_calc;

    localparam int BIT_CLKS  = 2624;            // 16 ticks of 164 clocks
    localparam int HALF_BIT  = BIT_CLKS / 2;
    localparam int START_TMO = 30 * BIT_CLKS;   // Longest wait for a start edge

    logic   i_clk;
    logic   i_reset;
    logic   i_rx;
    logic   o_tx;
    integer seed;
    int     errors;
    int     checks;

    uart_calc i_dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    always #10 i_clk = ~i_clk;

    // Opcode rule model with arithmetic taken modulo 256
    function automatic logic [7:0] expected_result(input logic [7:0] op,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
        int sum;
        int diff;
        sum  = int'(a) + int'(b);
        diff = int'(a) - int'(b) + 256;         // Kept non-negative
        case (op)
            8'h01:   return 8'(sum % 256);
            8'h02:   return 8'(diff % 256);
            8'h03:   return a & b;
            8'h04:   return a | b;
            default: return 8'h00;
        endcase
    endfunction

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};             // Stop, data LSB first, start
        @(posedge i_clk);
        #1;
        for (int i = 0; i < 10; i++)
        begin
            i_rx = frame[i];
            repeat (BIT_CLKS) @(posedge i_clk);
            #1;
        end
    endtask

    task automatic recv_byte(output logic [7:0] data, output logic ok);
        int   waited;
        logic start_ok;
        waited = 0;
        ok     = 1'b0;
        data   = '0;
        while (o_tx !== 1'b0 && waited < START_TMO)
        begin
            @(negedge i_clk);
            waited++;
        end
        checks++;
        assert (o_tx === 1'b0)
        else
        begin
            errors++;
            $display("Error: no start bit on o_tx within 30 bit periods");
        end
        if (o_tx === 1'b0)
        begin
            repeat (HALF_BIT) @(negedge i_clk);
            start_ok = (o_tx === 1'b0);
            assert (start_ok)
            else
            begin
                errors++;
                $display("Error: start bit on o_tx did not stay low to its middle");
            end
            for (int i = 0; i < 8; i++)
            begin
                repeat (BIT_CLKS) @(negedge i_clk);
                data[i] = o_tx;                 // Mid-bit sample
            end
            repeat (BIT_CLKS) @(negedge i_clk);
            assert (o_tx === 1'b1)
            else
            begin
                errors++;
                $display("Error: stop bit of the result frame was not high");
            end
            ok = start_ok && (o_tx === 1'b1);
        end
    endtask

    task automatic check_result(input logic [7:0] exp, input logic [7:0] got,
                                input logic ok);
        if (ok)
        begin
            checks++;
            assert (got === exp)
            else
            begin
                errors++;
                $display("[FAIL] o_tx result expected %h got %h", exp, got);
            end
        end
    endtask

    task automatic run_cmd(input logic [7:0] op, input logic [7:0] a,
                           input logic [7:0] b);
        logic [7:0] got;
        logic       ok;
        send_byte(op);
        send_byte(a);
        fork                                    // Answer starts inside the last frame
            send_byte(b);
            recv_byte(got, ok);
        join
        check_result(expected_result(op, a, b), got, ok);
    endtask

    task automatic reset_idle;
        int low_seen;
        low_seen = 0;
        repeat (2 * BIT_CLKS)
        begin
            @(negedge i_clk);
            if (o_tx !== 1'b1)
                low_seen++;
        end
        checks++;
        assert (low_seen == 0)
        else
        begin
            errors++;
            $display("Error: o_tx left idle after reset with no command sent");
        end
    endtask

    task automatic arith_cases(input logic [7:0] op);
        logic [7:0] a;
        logic [7:0] b;
        repeat (2)
        begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            run_cmd(op, a, b);
        end
    endtask

    task automatic back_to_back;
        logic [7:0] got1, got2;
        logic       ok1, ok2;
        logic [7:0] a, b, c, d;
        a = 8'($random(seed));
        b = 8'($random(seed));
        c = 8'($random(seed));
        d = 8'($random(seed));
        send_byte(8'h01);
        send_byte(a);
        fork
            begin
                send_byte(b);
                send_byte(8'h02);               // Second command with no gap
                send_byte(c);
                send_byte(d);
            end
            begin
                recv_byte(got1, ok1);
                recv_byte(got2, ok2);
            end
        join
        check_result(expected_result(8'h01, a, b), got1, ok1);
        check_result(expected_result(8'h02, c, d), got2, ok2);
    endtask

    initial
    begin
        i_clk   = 1'b0;
        i_reset = 1'b1;
        i_rx    = 1'b1;                         // Line idle
        errors  = 0;
        checks  = 0;
        seed    = 32'he6bf5561;
        repeat (10) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        reset_idle();
        run_cmd(8'h01, 8'hFF, 8'h01);           // Wraps to zero
        run_cmd(8'h01, 8'h12, 8'h34);
        arith_cases(8'h01);
        run_cmd(8'h02, 8'h00, 8'h01);           // Wraps to FF
        run_cmd(8'h02, 8'h50, 8'h20);
        arith_cases(8'h02);
        arith_cases(8'h03);
        arith_cases(8'h04);
        run_cmd(8'h00, 8'h5A, 8'hA5);
        run_cmd(8'h7E, 8'h33, 8'h44);
        back_to_back();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* uart_calc.f */
design/uart_pkg.sv
design/calc_pkg.sv
design/baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_fifo.sv
design/uart_top.sv
design/uart_calc.sv
verification/tb_uart_calc.sv

/* run.sh */
#!/bin/sh
# Build and run the uart_calc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uart_calc -f uart_calc.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
